/* pe_dot_cfg_pkg.sv */
// ********************
// configuration record of one dot-product unit
// dot_size must be a power of two, at least 2
// dot_latency must cover lane plus adder tree latency
// widths count the sign bit of each word
// ********************

package pe_dot_cfg_pkg;

  // one record sizes the whole unit, passed down from the top
  typedef struct packed {
    // bits per feature word, sign on top
    int feature_width;
    // bits per filter word, sign on top
    int filter_width;
    // number of pairs per vector
    int dot_size;
    // cycles from sampled inputs to o_result
    int dot_latency;
  } pe_dot_cfg_t;

  // 8b x 8b words, 8 pairs, 8 cycles
  localparam pe_dot_cfg_t PE_DOT_CFG_DEFAULT = '{
    feature_width: 8,
    filter_width:  8,
    dot_size:      8,
    dot_latency:   8
  };

  // product of the two magnitudes, signs stripped
  function automatic int mag_width(pe_dot_cfg_t c);
    return c.feature_width + c.filter_width - 2;
  endfunction

  // sign conversion level plus one level per halving
  function automatic int tree_latency(pe_dot_cfg_t c);
    return $clog2(c.dot_size) + 1;
  endfunction

  // two's complement sum, one growth bit per adder level
  function automatic int result_width(pe_dot_cfg_t c);
    return mag_width(c) + 1 + $clog2(c.dot_size);
  endfunction

endpackage

/* pe_dot_num_pkg.sv */
// ********************
// sign-magnitude number format of the lanes
// products wider than MAX_MAG_WIDTH are not supported
// magnitudes are zero-extended into the struct
// ********************

package pe_dot_num_pkg;

  // widest product magnitude a lane can hand over
  localparam int MAX_MAG_WIDTH = 30;

  // register stages inside one multiplier lane
  localparam int MULT_LATENCY = 2;

  // lane product as it travels to the adder tree
  // sign is the xor of both word signs
  // magnitude holds mag_width(cfg) valid bits, upper bits zero
  typedef struct packed {
    logic                     sign;
    logic [MAX_MAG_WIDTH-1:0] magnitude;
  } sm_product_t;

  // reset value of a lane output, positive zero
  localparam sm_product_t SM_PRODUCT_ZERO = '{
    sign:      1'b0,
    magnitude: '0
  };

endpackage

/* pe_mult_lane.sv */
// ********************
// one sign-magnitude multiplier lane, two cycles
// no valid strobe, a product is produced every cycle
// magnitude limited to MAX_MAG_WIDTH bits
// ********************

`timescale 1ns/100ps

module pe_mult_lane #(
  parameter pe_dot_cfg_pkg::pe_dot_cfg_t cfg = pe_dot_cfg_pkg::PE_DOT_CFG_DEFAULT
) (
  input  logic                          clock,
  input  logic                          i_arst_n,
  input  logic [cfg.feature_width-1:0]  i_feature,
  input  logic [cfg.filter_width-1:0]   i_filter,
  output pe_dot_num_pkg::sm_product_t   o_product
);

  import pe_dot_cfg_pkg::*;
  import pe_dot_num_pkg::*;

  localparam int FEAT_MAG_W = cfg.feature_width - 1;
  localparam int FILT_MAG_W = cfg.filter_width - 1;
  localparam int MAG_W      = mag_width(cfg);

  logic [FEAT_MAG_W-1:0] feat_mag;
  logic [FILT_MAG_W-1:0] filt_mag;
  logic                  sign_in;
  logic [MAG_W-1:0]      mag_q;
  logic                  sign_q;

  // split words, sign is the top bit
  assign feat_mag = i_feature[FEAT_MAG_W-1:0];
  assign filt_mag = i_filter[FILT_MAG_W-1:0];
  assign sign_in  = i_feature[cfg.feature_width-1] ^ i_filter[cfg.filter_width-1];

  // stage one, unsigned magnitude product
  always_ff @(posedge clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mag_q  <= '0;
      sign_q <= 1'b0;
    end else begin
      mag_q  <= MAG_W'(feat_mag) * MAG_W'(filt_mag);
      sign_q <= sign_in;
    end
  end

  // stage two, pack into the shared product struct
  always_ff @(posedge clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_product <= SM_PRODUCT_ZERO;
    end else begin
      o_product.sign      <= sign_q;
      // zero-extend to the struct width
      o_product.magnitude <= MAX_MAG_WIDTH'(mag_q);
    end
  end

  // top product bits would be lost in the struct
  a_mag_fits: assert property (@(posedge clock) MAG_W <= MAX_MAG_WIDTH)
    else $error("product magnitude %0d bits exceeds %0d", MAG_W, MAX_MAG_WIDTH);

endmodule

/* pe_adder_tree.sv */
// ********************
// registered adder tree over dot_size lane products
// dot_size must be a power of two, at least 2
// latency is tree_latency(cfg), one conversion level
// plus one level per halving, no overflow possible
// ********************

`timescale 1ns/100ps

module pe_adder_tree #(
  parameter pe_dot_cfg_pkg::pe_dot_cfg_t cfg = pe_dot_cfg_pkg::PE_DOT_CFG_DEFAULT
) (
  input  logic                                                clock,
  input  logic                                                i_arst_n,
  input  pe_dot_num_pkg::sm_product_t [cfg.dot_size-1:0]      i_products,
  output logic signed [pe_dot_cfg_pkg::result_width(cfg)-1:0] o_sum
);

  import pe_dot_cfg_pkg::*;

  localparam int MAG_W    = mag_width(cfg);
  localparam int LEVELS   = tree_latency(cfg) - 1;

  // level 0 holds the converted products, level LEVELS the root
  for (genvar l = 0; l <= LEVELS; l++) begin : gen_level
    // one extra bit per level keeps every sum exact
    localparam int LW    = MAG_W + 1 + l;
    localparam int NODES = cfg.dot_size >> l;

    logic signed [LW-1:0] sum_q [NODES];

    if (l == 0) begin : gen_conv
      // sign-magnitude to two's complement
      always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
          for (int j = 0; j < NODES; j++) begin
            sum_q[j] <= '0;
          end
        end else begin
          for (int j = 0; j < NODES; j++) begin
            // negating a zero magnitude gives zero, so -0 drops out here
            if (i_products[j].sign) begin
              sum_q[j] <= -$signed({1'b0, i_products[j].magnitude[MAG_W-1:0]});
            end else begin
              sum_q[j] <= $signed({1'b0, i_products[j].magnitude[MAG_W-1:0]});
            end
          end
        end
      end
    end else begin : gen_add
      // pairwise sums of the level below
      always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
          for (int j = 0; j < NODES; j++) begin
            sum_q[j] <= '0;
          end
        end else begin
          for (int j = 0; j < NODES; j++) begin
            sum_q[j] <= LW'(gen_level[l-1].sum_q[2*j]) +
                        LW'(gen_level[l-1].sum_q[2*j+1]);
          end
        end
      end
    end
  end

  // root is exactly result_width bits wide
  assign o_sum = gen_level[LEVELS].sum_q[0];

  // pairing needs a full binary tree
  a_dot_size_pow2: assert property (@(posedge clock)
    (cfg.dot_size >= 2) && ((cfg.dot_size & (cfg.dot_size - 1)) == 0))
    else $error("dot_size %0d is not a power of two >= 2", cfg.dot_size);

endmodule

/* pe_delay_line.sv */
// ********************
// shift register padding the result path
// depth of zero or less is a plain pass-through
// cleared by reset, no enable
// ********************

`timescale 1ns/100ps

module pe_delay_line #(
  parameter pe_dot_cfg_pkg::pe_dot_cfg_t cfg = pe_dot_cfg_pkg::PE_DOT_CFG_DEFAULT,
  parameter int width = pe_dot_cfg_pkg::result_width(cfg),
  parameter int depth = cfg.dot_latency - pe_dot_num_pkg::MULT_LATENCY -
                        pe_dot_cfg_pkg::tree_latency(cfg)
) (
  input  logic             clock,
  input  logic             i_arst_n,
  input  logic [width-1:0] i_data,
  output logic [width-1:0] o_data
);

  if (depth > 0) begin : gen_shift
    logic [width-1:0] stage_q [depth];

    always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
        for (int i = 0; i < depth; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= i_data;
        // older entries move one step each cycle
        for (int i = 1; i < depth; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign o_data = stage_q[depth-1];
  end else begin : gen_bypass
    // lane and tree already use the whole budget
    assign o_data = i_data;
  end

endmodule

/* pe_dot_unit.sv */
// ********************
// sign-magnitude dot product, two's complement result
// one vector pair accepted per cycle, no handshake
// result valid exactly dot_latency cycles later
// dot_latency >= MULT_LATENCY + tree_latency(cfg)
// ********************

`timescale 1ns/100ps

module pe_dot_unit #(
  parameter pe_dot_cfg_pkg::pe_dot_cfg_t cfg = pe_dot_cfg_pkg::PE_DOT_CFG_DEFAULT
) (
  input  logic                                                clock,
  input  logic                                                i_arst_n,
  input  logic [cfg.dot_size-1:0][cfg.feature_width-1:0]      i_feature,
  input  logic [cfg.dot_size-1:0][cfg.filter_width-1:0]       i_filter,
  output logic signed [pe_dot_cfg_pkg::result_width(cfg)-1:0] o_result
);

  import pe_dot_cfg_pkg::*;
  import pe_dot_num_pkg::*;

  localparam int RESULT_W  = result_width(cfg);
  // whatever the lanes and tree leave of the budget
  localparam int PAD_DEPTH = cfg.dot_latency - MULT_LATENCY - tree_latency(cfg);

  sm_product_t [cfg.dot_size-1:0] products;
  logic signed [RESULT_W-1:0]     tree_sum;

  // lane k takes word k of each vector
  for (genvar k = 0; k < cfg.dot_size; k++) begin : gen_lane
    pe_mult_lane #(
      .cfg(cfg)
    ) i_pe_mult_lane (
      .clock    (clock),
      .i_arst_n (i_arst_n),
      .i_feature(i_feature[k]),
      .i_filter (i_filter[k]),
      .o_product(products[k])
    );
  end

  // sums all lanes in registered levels
  pe_adder_tree #(
    .cfg(cfg)
  ) i_pe_adder_tree (
    .clock     (clock),
    .i_arst_n  (i_arst_n),
    .i_products(products),
    .o_sum     (tree_sum)
  );

  // pads to the configured total latency
  pe_delay_line #(
    .cfg  (cfg),
    .width(RESULT_W),
    .depth(PAD_DEPTH)
  ) i_pe_delay_line (
    .clock   (clock),
    .i_arst_n(i_arst_n),
    .i_data  (tree_sum),
    .o_data  (o_result)
  );

  // budget too small would need a negative delay
  a_latency_budget: assert property (@(posedge clock)
    cfg.dot_latency >= MULT_LATENCY + tree_latency(cfg))
    else $error("dot_latency %0d below lane plus tree latency %0d",
                cfg.dot_latency, MULT_LATENCY + tree_latency(cfg));

endmodule

/* tb_pe_dot_checker.sv */
// ********************
// result checker for pe_dot_unit
// one expected entry per sampled vector
// due dot_latency register stages later
// o_result compared on the falling edge
// ********************

`timescale 1ns/100ps

module tb_pe_dot_checker #(
  parameter pe_dot_cfg_pkg::pe_dot_cfg_t cfg = pe_dot_cfg_pkg::PE_DOT_CFG_DEFAULT,
  parameter int num_tests = 5
) (
  input  logic                                                clock,
  input  logic                                                i_arst_n,
  input  logic signed [pe_dot_cfg_pkg::result_width(cfg)-1:0] i_result,
  input  logic                                                i_exp_valid,
  input  logic                                                i_exp_last,
  input  logic [2:0]                                          i_exp_test,
  input  int                                                  i_exp_value,
  output int                                                  o_error_count,
  output int                                                  o_check_count,
  output int                                                  o_tests_done
);

  // one model result waiting for its cycle
  typedef struct packed {
    logic [2:0] test;
    logic       last;
    int         value;
    int         due;
  } exp_entry_t;

  exp_entry_t pending_q [$];
  int         cycle       = 0;
  logic       first_seen  = 1'b0;
  int         error_count = 0;
  int         check_count = 0;
  int         tests_done  = 0;
  // index 0 collects the idle checks after the first test
  int         test_checks [0:num_tests] = '{default: 0};
  int         test_errors [0:num_tests] = '{default: 0};

  assign o_error_count = error_count;
  assign o_check_count = check_count;
  assign o_tests_done  = tests_done;

  function automatic string test_name(input int test_id);
    case (test_id)
      1:       return "reset_zero";
      2:       return "random_stream";
      3:       return "negative_zero";
      4:       return "extremes";
      5:       return "sign_cancel";
      default: return "idle";
    endcase
  endfunction

  task automatic compare_value(input int test_id, input int expected,
                               input logic signed [31:0] actual);
    check_count++;
    test_checks[test_id]++;
    if (actual !== expected) begin
      error_count++;
      test_errors[test_id]++;
      $display("[ERROR] t=%0t o_result expected %0d actual %0d (test %0d)",
               $time, expected, actual, test_id);
    end
  endtask

  task automatic report_test(input int test_id);
    $display("test %0d %s: %0d checks, %0d errors, %s", test_id, test_name(test_id),
             test_checks[test_id], test_errors[test_id],
             (test_errors[test_id] == 0) ? "ok" : "FAILED");
    tests_done++;
  endtask

  // same edge the DUT samples the vector
  always @(posedge clock) begin : capture
    exp_entry_t entry;
    cycle = cycle + 1;
    if (i_arst_n && i_exp_valid) begin
      entry.test  = i_exp_test;
      entry.last  = i_exp_last;
      entry.value = i_exp_value;
      // this edge is the first of dot_latency register stages
      entry.due   = cycle + cfg.dot_latency - 1;
      pending_q.push_back(entry);
    end
  end

  always @(negedge clock) begin : compare
    exp_entry_t         entry;
    logic signed [31:0] actual;
    actual = 32'(i_result);
    if (pending_q.size() != 0 && pending_q[0].due == cycle) begin
      entry = pending_q.pop_front();
      // first vector out ends the reset zero window
      if (!first_seen) begin
        first_seen = 1'b1;
        report_test(1);
      end
      compare_value(int'(entry.test), entry.value, actual);
      if (entry.last) begin
        report_test(int'(entry.test));
      end
    end else begin
      // nothing emerging, pipeline still holds its reset zero
      compare_value(first_seen ? 0 : 1, 0, actual);
    end
  end

endmodule

/* tb_pe_dot_unit.sv */
// ********************
// testbench for pe_dot_unit, default record
// seeded random stimulus, model result per vector
// inputs change 0.5 ns after the rising edge
// watchdog bounds the run
// ********************

`timescale 1ns/100ps

module tb_pe_dot_unit;

  import pe_dot_cfg_pkg::*;

  localparam pe_dot_cfg_t CFG = PE_DOT_CFG_DEFAULT;
  localparam int DOT      = CFG.dot_size;
  localparam int FW       = CFG.feature_width;
  localparam int GW       = CFG.filter_width;
  localparam int RESULT_W = result_width(CFG);

  localparam int NUM_TESTS        = 5;
  localparam int RESET_CYCLES     = 8;
  localparam int IDLE_CYCLES      = 2;
  localparam int RANDOM_VECTORS   = 500;
  localparam int NEG_ZERO_VECTORS = 41;
  localparam int EXTREME_VECTORS  = 4;
  localparam int CANCEL_VECTORS   = 40;
  localparam int TOTAL_VECTORS    = RANDOM_VECTORS + NEG_ZERO_VECTORS +
                                    EXTREME_VECTORS + CANCEL_VECTORS;
  // reset and idle lead-in, every vector, then the pipeline drain
  localparam int WATCHDOG_CYCLES  = RESET_CYCLES + IDLE_CYCLES + TOTAL_VECTORS +
                                    CFG.dot_latency + 20;
  // all magnitudes at their maximum, every product with one sign
  localparam int MAX_SUM = DOT * (2 ** (FW - 1) - 1) * (2 ** (GW - 1) - 1);

  typedef logic [DOT-1:0][FW-1:0] feat_vec_t;
  typedef logic [DOT-1:0][GW-1:0] filt_vec_t;

  logic                       clock = 1'b0;
  logic                       arst_n;
  feat_vec_t                  feature;
  filt_vec_t                  filter;
  logic signed [RESULT_W-1:0] result;

  // model side, one entry per driven vector
  logic       exp_valid;
  logic       exp_last;
  logic [2:0] exp_test;
  int         exp_value;

  int     error_count;
  int     check_count;
  int     tests_done;
  integer seed;

  pe_dot_unit #(
    .cfg(CFG)
  ) i_pe_dot_unit (
    .clock    (clock),
    .i_arst_n (arst_n),
    .i_feature(feature),
    .i_filter (filter),
    .o_result (result)
  );

  tb_pe_dot_checker #(
    .cfg      (CFG),
    .num_tests(NUM_TESTS)
  ) i_checker (
    .clock        (clock),
    .i_arst_n     (arst_n),
    .i_result     (result),
    .i_exp_valid  (exp_valid),
    .i_exp_last   (exp_last),
    .i_exp_test   (exp_test),
    .i_exp_value  (exp_value),
    .o_error_count(error_count),
    .o_check_count(check_count),
    .o_tests_done (tests_done)
  );

  // 4 ns period
  always #2 clock = ~clock;

  // sum of signed products, sign is the xor of the word signs
  function automatic int dot_model(input feat_vec_t f, input filt_vec_t g);
    int acc;
    int prod;
    acc = 0;
    for (int k = 0; k < DOT; k++) begin
      prod = int'(f[k][FW-2:0]) * int'(g[k][GW-2:0]);
      if (f[k][FW-1] != g[k][GW-1]) begin
        acc = acc - prod;
      end else begin
        acc = acc + prod;
      end
    end
    return acc;
  endfunction

  task automatic drive_vector(input feat_vec_t f, input filt_vec_t g, input int expected,
                              input int test_id, input logic last);
    @(posedge clock);
    #0.5;
    feature   = f;
    filter    = g;
    exp_valid = 1'b1;
    exp_last  = last;
    exp_test  = 3'(test_id);
    exp_value = expected;
  endtask

  task automatic drive_idle();
    @(posedge clock);
    #0.5;
    feature   = '0;
    filter    = '0;
    exp_valid = 1'b0;
    exp_last  = 1'b0;
    exp_test  = '0;
    exp_value = 0;
  endtask

  task automatic random_vectors(output feat_vec_t f, output filt_vec_t g);
    for (int k = 0; k < DOT; k++) begin
      f[k] = FW'($random(seed));
      g[k] = GW'($random(seed));
    end
  endtask

  // back to back, full pipeline in flight
  task automatic run_random_stream();
    feat_vec_t f;
    filt_vec_t g;
    for (int n = 0; n < RANDOM_VECTORS; n++) begin
      random_vectors(f, g);
      drive_vector(f, g, dot_model(f, g), 2, n == RANDOM_VECTORS - 1);
    end
  endtask

  task automatic run_negative_zero();
    feat_vec_t   f;
    filt_vec_t   g;
    logic [31:0] pick;
    for (int n = 0; n < NEG_ZERO_VECTORS - 1; n++) begin
      random_vectors(f, g);
      pick = $random(seed);
      // sign set, magnitude zero, on random words
      for (int k = 0; k < DOT; k++) begin
        if (pick[2*k]) begin
          f[k] = {1'b1, {(FW-1){1'b0}}};
        end
        if (pick[2*k+1]) begin
          g[k] = {1'b1, {(GW-1){1'b0}}};
        end
      end
      drive_vector(f, g, dot_model(f, g), 3, 1'b0);
    end
    // every word a negative zero
    for (int k = 0; k < DOT; k++) begin
      f[k] = {1'b1, {(FW-1){1'b0}}};
      g[k] = {1'b1, {(GW-1){1'b0}}};
    end
    drive_vector(f, g, 0, 3, 1'b1);
  endtask

  task automatic run_extremes();
    feat_vec_t f_pos;
    feat_vec_t f_neg;
    filt_vec_t g_pos;
    filt_vec_t g_neg;
    for (int k = 0; k < DOT; k++) begin
      f_pos[k] = {1'b0, {(FW-1){1'b1}}};
      f_neg[k] = {1'b1, {(FW-1){1'b1}}};
      g_pos[k] = {1'b0, {(GW-1){1'b1}}};
      g_neg[k] = {1'b1, {(GW-1){1'b1}}};
    end
    // signs agree, then disagree
    drive_vector(f_pos, g_pos, MAX_SUM, 4, 1'b0);
    drive_vector(f_neg, g_neg, MAX_SUM, 4, 1'b0);
    drive_vector(f_pos, g_neg, -MAX_SUM, 4, 1'b0);
    drive_vector(f_neg, g_pos, -MAX_SUM, 4, 1'b1);
  endtask

  task automatic run_sign_cancel();
    feat_vec_t   f;
    filt_vec_t   g;
    logic [31:0] word;
    for (int n = 0; n < CANCEL_VECTORS; n++) begin
      for (int k = 0; k < DOT; k += 2) begin
        word = $random(seed);
        f[k] = FW'(word);
        g[k] = GW'(word >> 16);
        // same magnitudes, feature sign flipped, product sign flips
        f[k+1] = {~f[k][FW-1], f[k][FW-2:0]};
        g[k+1] = g[k];
      end
      drive_vector(f, g, 0, 5, n == CANCEL_VECTORS - 1);
    end
  endtask

  initial begin : stimulus
    feat_vec_t reset_f;
    filt_vec_t reset_g;
    seed      = 32'h97d5;
    arst_n    = 1'b1;
    feature   = '0;
    filter    = '0;
    exp_valid = 1'b0;
    exp_last  = 1'b0;
    exp_test  = '0;
    exp_value = 0;
    // falling reset edge after time zero
    #1 arst_n = 1'b0;
    // busy inputs while reset holds the pipeline
    repeat (RESET_CYCLES) begin
      random_vectors(reset_f, reset_g);
      feature = reset_f;
      filter  = reset_g;
      @(posedge clock);
      #0.5;
    end
    feature = '0;
    filter  = '0;
    arst_n  = 1'b1;
    repeat (IDLE_CYCLES) drive_idle();
    run_random_stream();
    run_negative_zero();
    run_extremes();
    run_sign_cancel();
    drive_idle();
    wait (tests_done == NUM_TESTS);
    $display("summary: %0d checks, %0d errors, %0d of %0d tests finished",
             check_count, error_count, tests_done, NUM_TESTS);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout: tests not finished after %0d cycles, %0d of %0d tests done",
             WATCHDOG_CYCLES, tests_done, NUM_TESTS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* all.f */
pe_dot_cfg_pkg.sv
pe_dot_num_pkg.sv
pe_mult_lane.sv
pe_adder_tree.sv
pe_delay_line.sv
pe_dot_unit.sv
tb_pe_dot_checker.sv
tb_pe_dot_unit.sv

/* Makefile */
# Verilator build and run of the dot-product testbench
# every variable can be overridden, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_pe_dot_unit
RTL_TOP    ?= pe_dot_unit
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing -j 0 --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing -Wall --timescale $(TIMESCALE)

SOURCES     := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter-out tb_%,$(SOURCES))
BINARY      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) && echo "simulation passed" || \
		{ echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
